//--- common/exc_pkg.sv
`default_nettype none

package exc_pkg;

	typedef logic [31:0] word_t;
	typedef logic [6:0] irq_num_t;

	// Privilege mode as held in PSR[6:5]
	typedef enum logic [1:0] {
		MODE_KERNEL = 2'b00,
		MODE_USER = 2'b11
	} core_mode_t;

	// Memory operations the sequencer can ask for
	typedef enum logic [2:0] {
		MOP_VECTOR,
		MOP_WR_USPR,
		MOP_RD_USPR,
		MOP_WR_KSPR,
		MOP_RD_KSPR
	} mem_op_t;

	typedef enum logic [1:0] {EV_JUMP, EV_IRQ, EV_RET} ev_kind_t;

	typedef enum logic [1:0] {ST_IDLE, ST_BRANCH, ST_IRQ_ENTRY, ST_IRQ_RET} seq_state_t;

	localparam int PSR_IE_BIT = 2;
	localparam int PSR_MODE_LSB = 5;

	// Task state block placement
	localparam int TASK_STRIDE_SHIFT = 8;
	localparam int TASK_IDX_W = 14;
	localparam word_t TST_KSPR_OFS = 32'h0000_0008;
	localparam word_t TST_USPR_OFS = 32'h0000_000c;

	// Address space id sits in TIDR[31:18]
	localparam int ASID_W = 14;

	function automatic core_mode_t psr_mode(input word_t psr);
		return core_mode_t'(psr[PSR_MODE_LSB +: 2]);
	endfunction

endpackage

`default_nettype wire

//--- hw/exc_event_decode.sv
`timescale 1ns/1ps
`default_nettype none

module exc_event_decode import exc_pkg::*; #(
	parameter int IRQ_NUM_W = 7
) (
	input wire iCLOCK,
	input wire inRESET,
	input wire seq_idle,
	input wire jump,
	input wire irq_req,
	input wire irq_ret,
	input wire interrupt_lock,
	input wire ldst_lock,
	input wire word_t irq_fi0r,
	input wire [IRQ_NUM_W-1:0] irq_num,
	input wire word_t sysreg_spr,
	input wire word_t sysreg_tidr,
	input wire word_t sysreg_tisr,
	input wire word_t sysreg_psr,
	input wire word_t sysreg_ppsr,
	input wire word_t sysreg_pcr,
	input wire word_t sysreg_ppcr,
	input wire word_t sysreg_idtr,
	output logic ev_valid,
	output ev_kind_t ev_kind,
	output logic ev_irq_after_jump,
	output logic refresh,
	output logic pipeline_stop,
	output logic register_lock,
	output word_t snap_spr,
	output word_t snap_tidr,
	output word_t snap_tisr,
	output word_t snap_psr,
	output word_t snap_ppsr,
	output word_t snap_pcr,
	output word_t snap_ppcr,
	output word_t snap_idtr,
	output logic [IRQ_NUM_W-1:0] ev_irq_num,
	output word_t ev_fi0r
);

	logic irq_ok;
	logic sample;

	assign irq_ok = irq_req && !interrupt_lock && sysreg_psr[PSR_IE_BIT];

	// No sampling in the refresh cycle while the sequencer still shows idle
	assign sample = seq_idle && !ev_valid;

	assign refresh = ev_valid;
	assign pipeline_stop = !seq_idle || (irq_ok && !jump);
	// pc_set only ever occurs while the sequencer is busy
	assign register_lock = pipeline_stop || refresh;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ev_valid <= 1'b0;
			ev_kind <= EV_JUMP;
			ev_irq_after_jump <= 1'b0;
		end else begin
			ev_valid <= sample && (jump || irq_ok || irq_ret);
			if (sample) begin
				// Jump first, then interrupt, then return
				if (jump) begin
					ev_kind <= EV_JUMP;
				end else if (irq_ok) begin
					ev_kind <= EV_IRQ;
				end else begin
					ev_kind <= EV_RET;
				end
				// Behind a branch the load/store lock gates the interrupt
				ev_irq_after_jump <= jump && irq_req && !ldst_lock && sysreg_psr[PSR_IE_BIT];
			end
		end
	end

	// Register snapshot frozen while a sequence runs
	always_ff @(posedge iCLOCK) begin
		if (sample) begin
			snap_spr <= sysreg_spr;
			snap_tidr <= sysreg_tidr;
			snap_tisr <= sysreg_tisr;
			snap_psr <= sysreg_psr;
			snap_ppsr <= sysreg_ppsr;
			snap_pcr <= sysreg_pcr;
			snap_ppcr <= sysreg_ppcr;
			snap_idtr <= sysreg_idtr;
			ev_irq_num <= irq_num;
			ev_fi0r <= irq_fi0r;
		end
	end

endmodule

`default_nettype wire

//--- hw/exc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module exc_sequencer import exc_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	input wire ev_valid,
	input wire ev_kind_t ev_kind,
	input wire ev_irq_after_jump,
	input wire word_t snap_spr,
	input wire word_t snap_psr,
	input wire word_t snap_ppsr,
	input wire word_t snap_pcr,
	input wire word_t snap_ppcr,
	input wire word_t ev_fi0r,
	input wire word_t jump_addr,
	input wire mem_done,
	input wire word_t rdata,
	output logic seq_idle,
	output logic bus_claim,
	output logic mem_start,
	output mem_op_t mem_op,
	output word_t wdata,
	output logic pc_set,
	output word_t pc,
	output logic ppcr_set,
	output word_t ppcr,
	output logic fi0r_set,
	output word_t fi0r,
	output logic set_irq_mode,
	output logic clr_irq_mode,
	output logic spr_write,
	output word_t spr,
	output logic irq_ack
);

	// Steps shared by interrupt entry and return
	typedef enum logic [2:0] {
		STEP_VEC_REQ,
		STEP_VEC_WAIT,
		STEP_WR_REQ,
		STEP_WR_WAIT,
		STEP_RD_REQ,
		STEP_RD_WAIT,
		STEP_DONE
	} step_t;

	seq_state_t state;
	step_t step;
	word_t pc_q;
	logic in_mem_seq;
	logic is_entry;
	logic entry_swap;
	logic ret_swap;

	assign is_entry = (state == ST_IRQ_ENTRY);
	assign in_mem_seq = is_entry || (state == ST_IRQ_RET);

	// Stack pointer swap only when crossing the user/kernel boundary
	assign entry_swap = (psr_mode(snap_psr) != MODE_KERNEL);
	assign ret_swap = (psr_mode(snap_ppsr) == MODE_USER);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_IDLE;
			step <= STEP_VEC_REQ;
			spr_write <= 1'b0;
		end else begin
			spr_write <= 1'b0;
			case (state)
				ST_IDLE: begin
					step <= STEP_VEC_REQ;
					if (ev_valid) begin
						case (ev_kind)
							EV_JUMP: state <= ST_BRANCH;
							EV_IRQ: state <= ST_IRQ_ENTRY;
							default: begin
								state <= ST_IRQ_RET;
								step <= ret_swap ? STEP_WR_REQ : STEP_DONE;
							end
						endcase
					end
				end
				ST_BRANCH: begin
					step <= STEP_VEC_REQ;
					state <= ev_irq_after_jump ? ST_IRQ_ENTRY : ST_IDLE;
				end
				default: begin
					case (step)
						STEP_VEC_REQ: step <= STEP_VEC_WAIT;
						STEP_VEC_WAIT: begin
							if (mem_done) begin
								step <= entry_swap ? STEP_WR_REQ : STEP_DONE;
							end
						end
						STEP_WR_REQ: step <= STEP_WR_WAIT;
						STEP_WR_WAIT: begin
							if (mem_done) begin
								step <= STEP_RD_REQ;
							end
						end
						STEP_RD_REQ: step <= STEP_RD_WAIT;
						STEP_RD_WAIT: begin
							if (mem_done) begin
								step <= STEP_DONE;
								spr_write <= 1'b1;
							end
						end
						default: state <= ST_IDLE;
					endcase
				end
			endcase
		end
	end

	// Target PC tracks jump_addr while idle so the sampled value is kept
	always_ff @(posedge iCLOCK) begin
		if (state == ST_IDLE) begin
			if (!ev_valid) begin
				pc_q <= jump_addr;
			end else if (ev_kind == EV_RET) begin
				pc_q <= snap_ppcr;
			end
		end else if (step == STEP_VEC_WAIT && mem_done) begin
			pc_q <= rdata;
		end
		if (step == STEP_RD_WAIT && mem_done) begin
			spr <= rdata;
		end
	end

	always_comb begin
		case (step)
			STEP_WR_REQ: mem_op = is_entry ? MOP_WR_USPR : MOP_WR_KSPR;
			STEP_RD_REQ: mem_op = is_entry ? MOP_RD_KSPR : MOP_RD_USPR;
			default: mem_op = MOP_VECTOR;
		endcase
	end

	assign mem_start = in_mem_seq &&
		(step == STEP_VEC_REQ || step == STEP_WR_REQ || step == STEP_RD_REQ);
	assign wdata = snap_spr;

	assign seq_idle = (state == ST_IDLE);
	assign bus_claim = !seq_idle;

	assign pc_set = (state == ST_BRANCH && !ev_irq_after_jump) ||
		(in_mem_seq && step == STEP_DONE);
	assign pc = pc_q;

	// Entry directly after sampling, or after the branch cycle
	assign ppcr_set = (ev_valid && ev_kind == EV_IRQ) ||
		(state == ST_BRANCH && ev_irq_after_jump);
	assign ppcr = (state == ST_BRANCH) ? pc_q : snap_pcr;
	assign set_irq_mode = ppcr_set;

	assign irq_ack = is_entry && (step == STEP_DONE);
	assign fi0r_set = irq_ack;
	assign fi0r = ev_fi0r;
	assign clr_irq_mode = (state == ST_IRQ_RET) && (step == STEP_DONE);

endmodule

`default_nettype wire

//--- hw/exc_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module exc_mem_port import exc_pkg::*; #(
	parameter int IRQ_NUM_W = 7
) (
	input wire iCLOCK,
	input wire inRESET,
	input wire mem_start,
	input wire mem_op_t mem_op,
	input wire word_t wdata,
	input wire [IRQ_NUM_W-1:0] irq_num,
	input wire word_t tidr,
	input wire word_t tisr,
	input wire word_t idtr,
	input wire ldst_busy,
	input wire ldst_valid,
	input wire word_t ldst_rdata,
	output logic mem_done,
	output word_t rdata,
	output logic ldst_req,
	output logic ldst_rw,
	output word_t ldst_addr,
	output word_t ldst_wdata,
	output logic [ASID_W-1:0] asid
);

	typedef enum logic [1:0] {PORT_IDLE, PORT_REQ, PORT_RESP} port_state_t;

	port_state_t state;
	word_t task_base;
	word_t vec_addr;
	word_t next_addr;
	logic next_rw;

	// Task state block of the current task
	assign task_base = tisr + {{(32 - TASK_IDX_W - TASK_STRIDE_SHIFT){1'b0}},
		tidr[TASK_IDX_W-1:0], {TASK_STRIDE_SHIFT{1'b0}}};

	// IDT entries are 8 bytes with the handler address in the upper word
	assign vec_addr = idtr + {{(32 - IRQ_NUM_W - 3){1'b0}}, irq_num, 3'b000} + 32'h4;

	always_comb begin
		next_addr = vec_addr;
		next_rw = 1'b0;
		case (mem_op)
			MOP_WR_USPR: begin
				next_addr = task_base + TST_USPR_OFS;
				next_rw = 1'b1;
			end
			MOP_RD_USPR: next_addr = task_base + TST_USPR_OFS;
			MOP_WR_KSPR: begin
				next_addr = task_base + TST_KSPR_OFS;
				next_rw = 1'b1;
			end
			MOP_RD_KSPR: next_addr = task_base + TST_KSPR_OFS;
			default: next_addr = vec_addr;
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= PORT_IDLE;
			mem_done <= 1'b0;
		end else begin
			mem_done <= 1'b0;
			case (state)
				PORT_IDLE: begin
					if (mem_start) begin
						state <= PORT_REQ;
					end
				end
				// Held until the bus is not busy
				PORT_REQ: begin
					if (!ldst_busy) begin
						state <= PORT_RESP;
					end
				end
				default: begin
					if (ldst_valid) begin
						state <= PORT_IDLE;
						mem_done <= 1'b1;
					end
				end
			endcase
		end
	end

	// Request fields latched at start and held through the handshake
	always_ff @(posedge iCLOCK) begin
		if (state == PORT_IDLE && mem_start) begin
			ldst_addr <= next_addr;
			ldst_rw <= next_rw;
			ldst_wdata <= wdata;
		end
		if (state == PORT_RESP && ldst_valid) begin
			rdata <= ldst_rdata;
		end
	end

	assign ldst_req = (state == PORT_REQ);
	assign asid = tidr[31 -: ASID_W];

endmodule

`default_nettype wire

//--- hw/exception_manager.sv
`timescale 1ns/1ps
`default_nettype none

module exception_manager import exc_pkg::*; #(
	parameter int IRQ_NUM_W = $bits(irq_num_t)
) (
	input wire iCLOCK,
	input wire inRESET,
	// Core events
	input wire jump,
	input wire word_t jump_addr,
	input wire irq_req,
	input wire [IRQ_NUM_W-1:0] irq_num,
	input wire word_t irq_fi0r,
	input wire irq_ret,
	input wire interrupt_lock,
	input wire ldst_lock,
	input wire word_t sysreg_spr,
	input wire word_t sysreg_tidr,
	input wire word_t sysreg_tisr,
	input wire word_t sysreg_psr,
	input wire word_t sysreg_ppsr,
	input wire word_t sysreg_pcr,
	input wire word_t sysreg_ppcr,
	input wire word_t sysreg_idtr,
	// Pipeline control
	output logic register_lock,
	output logic pipeline_stop,
	output logic refresh,
	output logic pc_set,
	output word_t pc,
	output logic ppcr_set,
	output word_t ppcr,
	output logic fi0r_set,
	output word_t fi0r,
	output logic set_irq_mode,
	output logic clr_irq_mode,
	output logic spr_write,
	output word_t spr,
	output logic irq_ack,
	// Load/store bus
	output logic bus_claim,
	output logic ldst_req,
	input wire ldst_busy,
	output logic ldst_rw,
	output word_t ldst_addr,
	output word_t ldst_wdata,
	output logic [ASID_W-1:0] asid,
	input wire ldst_valid,
	input wire word_t ldst_rdata
);

	logic seq_idle;
	logic ev_valid;
	ev_kind_t ev_kind;
	logic ev_irq_after_jump;
	word_t snap_spr;
	word_t snap_tidr;
	word_t snap_tisr;
	word_t snap_psr;
	word_t snap_ppsr;
	word_t snap_pcr;
	word_t snap_ppcr;
	word_t snap_idtr;
	logic [IRQ_NUM_W-1:0] ev_irq_num;
	word_t ev_fi0r;
	logic mem_start;
	mem_op_t mem_op;
	word_t mem_wdata;
	logic mem_done;
	word_t mem_rdata;

	exc_event_decode #(
		.IRQ_NUM_W(IRQ_NUM_W)
	) u_decode (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.seq_idle(seq_idle),
		.jump(jump),
		.irq_req(irq_req),
		.irq_ret(irq_ret),
		.interrupt_lock(interrupt_lock),
		.ldst_lock(ldst_lock),
		.irq_fi0r(irq_fi0r),
		.irq_num(irq_num),
		.sysreg_spr(sysreg_spr),
		.sysreg_tidr(sysreg_tidr),
		.sysreg_tisr(sysreg_tisr),
		.sysreg_psr(sysreg_psr),
		.sysreg_ppsr(sysreg_ppsr),
		.sysreg_pcr(sysreg_pcr),
		.sysreg_ppcr(sysreg_ppcr),
		.sysreg_idtr(sysreg_idtr),
		.ev_valid(ev_valid),
		.ev_kind(ev_kind),
		.ev_irq_after_jump(ev_irq_after_jump),
		.refresh(refresh),
		.pipeline_stop(pipeline_stop),
		.register_lock(register_lock),
		.snap_spr(snap_spr),
		.snap_tidr(snap_tidr),
		.snap_tisr(snap_tisr),
		.snap_psr(snap_psr),
		.snap_ppsr(snap_ppsr),
		.snap_pcr(snap_pcr),
		.snap_ppcr(snap_ppcr),
		.snap_idtr(snap_idtr),
		.ev_irq_num(ev_irq_num),
		.ev_fi0r(ev_fi0r)
	);

	exc_sequencer u_seq (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.ev_valid(ev_valid),
		.ev_kind(ev_kind),
		.ev_irq_after_jump(ev_irq_after_jump),
		.snap_spr(snap_spr),
		.snap_psr(snap_psr),
		.snap_ppsr(snap_ppsr),
		.snap_pcr(snap_pcr),
		.snap_ppcr(snap_ppcr),
		.ev_fi0r(ev_fi0r),
		.jump_addr(jump_addr),
		.mem_done(mem_done),
		.rdata(mem_rdata),
		.seq_idle(seq_idle),
		.bus_claim(bus_claim),
		.mem_start(mem_start),
		.mem_op(mem_op),
		.wdata(mem_wdata),
		.pc_set(pc_set),
		.pc(pc),
		.ppcr_set(ppcr_set),
		.ppcr(ppcr),
		.fi0r_set(fi0r_set),
		.fi0r(fi0r),
		.set_irq_mode(set_irq_mode),
		.clr_irq_mode(clr_irq_mode),
		.spr_write(spr_write),
		.spr(spr),
		.irq_ack(irq_ack)
	);

	exc_mem_port #(
		.IRQ_NUM_W(IRQ_NUM_W)
	) u_mem (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.mem_start(mem_start),
		.mem_op(mem_op),
		.wdata(mem_wdata),
		.irq_num(ev_irq_num),
		.tidr(snap_tidr),
		.tisr(snap_tisr),
		.idtr(snap_idtr),
		.ldst_busy(ldst_busy),
		.ldst_valid(ldst_valid),
		.ldst_rdata(ldst_rdata),
		.mem_done(mem_done),
		.rdata(mem_rdata),
		.ldst_req(ldst_req),
		.ldst_rw(ldst_rw),
		.ldst_addr(ldst_addr),
		.ldst_wdata(ldst_wdata),
		.asid(asid)
	);

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic iCLOCK,
	output logic inRESET
);

	initial begin
		iCLOCK = 1'b0;
		forever #(PERIOD / 2) iCLOCK = ~iCLOCK;
	end

	// Release away from the rising edge
	initial begin
		inRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
	end

endmodule

`default_nettype wire

//--- dv/exc_properties.sv
`timescale 1ns/1ps
`default_nettype none

module exc_properties (
	input wire iCLOCK,
	input wire inRESET,
	input wire mem_start,
	input wire mem_done,
	input wire ldst_req,
	input wire ldst_busy,
	input wire ldst_rw,
	input wire [31:0] ldst_addr,
	input wire [31:0] ldst_wdata
);

	logic op_open;

	// One operation between start and done
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			op_open <= 1'b0;
		end else if (mem_start) begin
			op_open <= 1'b1;
		end else if (mem_done) begin
			op_open <= 1'b0;
		end
	end

	req_held: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ldst_req && ldst_busy |=> ldst_req && $stable(ldst_addr) &&
		$stable(ldst_rw) && $stable(ldst_wdata))
		else $error("request changed while the bus was busy");

	done_after_start: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_done |-> op_open)
		else $error("mem_done without a started operation");

	start_when_free: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_start |-> !op_open)
		else $error("mem_start while an operation was still open");

endmodule

bind exc_mem_port exc_properties u_props (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.mem_start(mem_start),
	.mem_done(mem_done),
	.ldst_req(ldst_req),
	.ldst_busy(ldst_busy),
	.ldst_rw(ldst_rw),
	.ldst_addr(ldst_addr),
	.ldst_wdata(ldst_wdata)
);

`default_nettype wire

//--- dv/tb_exception_manager.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exception_manager import exc_pkg::*; ();

	localparam int N_EVENTS = 400;
	localparam int TIMEOUT_CYCLES = N_EVENTS * 60 + 20;

	logic iCLOCK, inRESET;
	logic jump, irq_req, irq_ret, interrupt_lock, ldst_lock;
	word_t jump_addr, irq_fi0r;
	irq_num_t irq_num;
	word_t sysreg_spr, sysreg_tidr, sysreg_tisr, sysreg_psr;
	word_t sysreg_ppsr, sysreg_pcr, sysreg_ppcr, sysreg_idtr;
	logic register_lock, pipeline_stop, refresh, pc_set, ppcr_set, fi0r_set;
	logic set_irq_mode, clr_irq_mode, spr_write, irq_ack, bus_claim;
	word_t pc, ppcr, fi0r, spr;
	logic ldst_req, ldst_busy, ldst_rw, ldst_valid;
	word_t ldst_addr, ldst_wdata, ldst_rdata;
	logic [ASID_W-1:0] asid;

	// Expected bus transactions and the read data handed out
	word_t exp_addr_q[$];
	logic exp_rw_q[$];
	word_t exp_wd_q[$];
	word_t rd_q[$];

	int err_value, err_other, cycles, resp_wait;
	logic resp_pend;
	word_t resp_data, busy_roll;

	tb_clock_gen clock_gen (.iCLOCK(iCLOCK), .inRESET(inRESET));

	exception_manager uut (.*);

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			err_value++;
			$display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_mode_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			err_value++;
			$display("Fail %0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic check_mem_op(input word_t exp_addr, input logic exp_rw);
		if (exp_addr !== ldst_addr || exp_rw !== ldst_rw) begin
			err_value++;
			$display("Fail %0t ldst_addr/ldst_rw expected %h/%b actual %h/%b",
				$time, exp_addr, exp_rw, ldst_addr, ldst_rw);
		end
	endtask

	task automatic expect_op(input word_t addr, input logic rw, input word_t wd);
		exp_addr_q.push_back(addr);
		exp_rw_q.push_back(rw);
		exp_wd_q.push_back(wd);
	endtask

	// Bus acceptance seen at the rising edge
	always @(posedge iCLOCK) begin
		if (inRESET && ldst_req && !ldst_busy) begin
			if (exp_addr_q.size() == 0) begin
				err_other++;
				$display("Unexpected bus request at %0t to address %h", $time, ldst_addr);
			end else begin
				check_mem_op(exp_addr_q[0], exp_rw_q[0]);
				if (exp_rw_q[0]) begin
					check_word("ldst_wdata", exp_wd_q[0], ldst_wdata);
				end
				void'(exp_addr_q.pop_front());
				void'(exp_rw_q.pop_front());
				void'(exp_wd_q.pop_front());
			end
			resp_pend = 1'b1;
			resp_wait = 1 + int'($urandom % 5);
			resp_data = $urandom;
			if (!ldst_rw) begin
				rd_q.push_back(resp_data);
			end
		end
	end

	always @(negedge iCLOCK) begin
		busy_roll = $urandom;
		ldst_busy = (busy_roll[2:0] < 3'd3);
		ldst_valid = 1'b0;
		if (resp_pend) begin
			resp_wait--;
			if (resp_wait == 0) begin
				ldst_valid = 1'b1;
				ldst_rdata = resp_data;
				resp_pend = 1'b0;
			end
		end
	end

	always @(posedge iCLOCK) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic run_event();
		word_t r, base, exp_pc;
		logic do_jump, do_irq, do_ret, irq_ok, after, entry, ret_ev, any, swap;
		logic ppcr_now;
		int kind, k, rd_base, spr_cnt;
		logic seen_pc;
		while (register_lock) @(negedge iCLOCK);
		kind = int'($urandom % 4);
		r = $urandom;
		do_jump = (kind == 0 || kind == 3);
		do_irq = (kind == 1 || kind == 3);
		do_ret = (kind == 2) || (kind == 1 && r[0]);
		sysreg_psr = $urandom;
		sysreg_psr[6:5] = r[1] ? r[18:17] : 2'b00;
		sysreg_psr[PSR_IE_BIT] = (r[4:3] != 2'b00);
		sysreg_ppsr = $urandom;
		sysreg_ppsr[6:5] = r[5] ? 2'b11 : r[20:19];
		interrupt_lock = (r[7:6] == 2'b00);
		ldst_lock = (r[9:8] == 2'b00);
		sysreg_spr = $urandom;
		sysreg_tidr = $urandom;
		sysreg_tisr = $urandom;
		sysreg_pcr = $urandom;
		sysreg_ppcr = $urandom;
		sysreg_idtr = $urandom;
		jump_addr = $urandom;
		irq_fi0r = $urandom;
		irq_num = r[16:10];
		jump = do_jump;
		irq_req = do_irq;
		irq_ret = do_ret;

		// Reference model of the event decision
		irq_ok = do_irq && !interrupt_lock && sysreg_psr[PSR_IE_BIT];
		after = do_jump && do_irq && !ldst_lock && sysreg_psr[PSR_IE_BIT];
		entry = (!do_jump && irq_ok) || after;
		ret_ev = !do_jump && !irq_ok && do_ret;
		any = do_jump || irq_ok || do_ret;
		base = sysreg_tisr + {18'b0, sysreg_tidr[13:0]} * 32'd256;
		swap = 1'b0;
		if (entry) begin
			expect_op(sysreg_idtr + {25'b0, irq_num} * 32'd8 + 32'd4, 1'b0, 32'd0);
			swap = (sysreg_psr[6:5] != 2'b00);
			if (swap) begin
				expect_op(base + 32'd12, 1'b1, sysreg_spr);
				expect_op(base + 32'd8, 1'b0, 32'd0);
			end
		end else if (ret_ev && sysreg_ppsr[6:5] == 2'b11) begin
			swap = 1'b1;
			expect_op(base + 32'd8, 1'b1, sysreg_spr);
			expect_op(base + 32'd12, 1'b0, 32'd0);
		end
		rd_base = rd_q.size();

		// Sampling edge with the unit idle
		@(posedge iCLOCK);
		check_mode_flag("pipeline_stop", irq_ok && !do_jump, pipeline_stop);
		check_mode_flag("register_lock", irq_ok && !do_jump, register_lock);
		@(negedge iCLOCK);
		jump = 1'b0;
		irq_req = 1'b0;
		irq_ret = 1'b0;

		if (!any) begin
			repeat (4) begin
				@(posedge iCLOCK);
				check_mode_flag("refresh", 1'b0, refresh);
				check_mode_flag("bus_claim", 1'b0, bus_claim);
				check_mode_flag("pc_set", 1'b0, pc_set);
			end
			@(negedge iCLOCK);
			return;
		end

		k = 0;
		seen_pc = 1'b0;
		spr_cnt = 0;
		while (!seen_pc) begin
			@(posedge iCLOCK);
			k++;
			// Refresh cycle first, then busy until pc_set
			check_mode_flag("refresh", k == 1, refresh);
			check_mode_flag("register_lock", 1'b1, register_lock);
			check_mode_flag("bus_claim", k > 1, bus_claim);
			check_mode_flag("pipeline_stop", k > 1, pipeline_stop);
			ppcr_now = entry && (k == (after ? 2 : 1));
			check_mode_flag("ppcr_set", ppcr_now, ppcr_set);
			check_mode_flag("set_irq_mode", ppcr_now, set_irq_mode);
			if (ppcr_now) begin
				check_word("ppcr", after ? jump_addr : sysreg_pcr, ppcr);
			end
			if (spr_write) begin
				spr_cnt++;
				check_word("spr", rd_q[rd_q.size() - 1], spr);
			end
			if (!pc_set) begin
				check_mode_flag("irq_ack", 1'b0, irq_ack);
				check_mode_flag("fi0r_set", 1'b0, fi0r_set);
				check_mode_flag("clr_irq_mode", 1'b0, clr_irq_mode);
			end
			if (pc_set) begin
				seen_pc = 1'b1;
				if (entry) begin
					exp_pc = rd_q[rd_base];
				end else if (ret_ev) begin
					exp_pc = sysreg_ppcr;
				end else begin
					exp_pc = jump_addr;
				end
				check_word("pc", exp_pc, pc);
				check_mode_flag("irq_ack", entry, irq_ack);
				check_mode_flag("fi0r_set", entry, fi0r_set);
				if (entry) begin
					check_word("fi0r", irq_fi0r, fi0r);
				end
				check_mode_flag("clr_irq_mode", ret_ev, clr_irq_mode);
				check_word("asid", {18'b0, sysreg_tidr[31:18]}, {18'b0, asid});
				if (do_jump && !after && k != 2) begin
					err_other++;
					$display("Jump pc_set came %0d cycles after sampling, not 2", k);
				end
				if (spr_cnt != (swap ? 1 : 0)) begin
					err_other++;
					$display("Wrong number of spr_write pulses at %0t", $time);
				end
				if (exp_addr_q.size() != 0) begin
					err_other++;
					$display("Bus transactions missing at pc_set, time %0t", $time);
				end
			end
		end
		@(negedge iCLOCK);
	endtask

	initial begin
		void'($urandom(32'h9d9b5d71));
		err_value = 0;
		err_other = 0;
		cycles = 0;
		resp_pend = 1'b0;
		resp_wait = 0;
		jump = 1'b0;
		irq_req = 1'b0;
		irq_ret = 1'b0;
		interrupt_lock = 1'b0;
		ldst_lock = 1'b0;
		jump_addr = '0;
		irq_fi0r = '0;
		irq_num = '0;
		sysreg_spr = '0;
		sysreg_tidr = '0;
		sysreg_tisr = '0;
		sysreg_psr = '0;
		sysreg_ppsr = '0;
		sysreg_pcr = '0;
		sysreg_ppcr = '0;
		sysreg_idtr = '0;
		ldst_busy = 1'b0;
		ldst_valid = 1'b0;
		ldst_rdata = '0;
		@(posedge inRESET);
		@(negedge iCLOCK);
		repeat (N_EVENTS) run_event();
		if (exp_addr_q.size() != 0 || resp_pend) begin
			err_other++;
			$display("Bus traffic left over at the end of the run");
		end
		$display("Errors: %0d value, %0d other", err_value, err_other);
		if (err_value + err_other == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
common/exc_pkg.sv
hw/exc_event_decode.sv
hw/exc_sequencer.sv
hw/exc_mem_port.sv
hw/exception_manager.sv
dv/tb_clock_gen.sv
dv/exc_properties.sv
dv/tb_exception_manager.sv

//--- run.sh
#!/bin/bash
# Build and run the exception manager testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_exception_manager -f src.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
exit 0
